// ==== hw/cgra_defs.svh ====
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// array size
`define CGRA_NUM_PRR        4
`define CGRA_NUM_PRR_WIDTH  2

// config port, address is {prr id, 2 spare bits, register index}
`define CGRA_CFG_ADDR_WIDTH 8
`define CGRA_CFG_DATA_WIDTH 32
`define PRR_CFG_DEPTH       16

// stream side
`define CGRA_IO_WIDTH       16
`define PRR_FIFO_DEPTH      8
`define PRR_FIFO_CNT_WIDTH  4   // fits count 0..PRR_FIFO_DEPTH

`endif

// ==== hw/cgra_pkg.sv ====
`default_nettype none

package cgra_pkg;

    // datapath operation applied on the way out
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2,
        OP_SHL  = 2'd3
    } prr_op_t;

    // named config registers, 4..15 are scratch
    typedef enum logic [3:0] {
        REG_CTRL    = 4'd0,   // [0] glb2prr_on, [1] prr2glb_on
        REG_OP      = 4'd1,   // [1:0] opcode
        REG_OPERAND = 4'd2,   // [15:0] operand
        REG_STATUS  = 4'd3    // [0] overflow, [7:4] fifo count
    } cfg_reg_idx_t;

endpackage

`default_nettype wire

// ==== hw/prr_cfg_regs.sv ====
`default_nettype none

`include "cgra_defs.svh"

module prr_cfg_regs #(
    parameter int PRR_ID = 0
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  logic [`CGRA_CFG_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [`CGRA_CFG_DATA_WIDTH-1:0]    wr_data,
    input  logic                               rd_en,
    input  logic [`CGRA_CFG_ADDR_WIDTH-1:0]    rd_addr,
    input  logic                               overflow_set,
    input  logic [`PRR_FIFO_CNT_WIDTH-1:0]     fifo_count,
    output logic [`CGRA_CFG_DATA_WIDTH-1:0]    rd_data,
    output logic                               glb2prr_on,
    output logic                               prr2glb_on,
    output cgra_pkg::prr_op_t                  op,
    output logic [`CGRA_IO_WIDTH-1:0]          operand
);
    import cgra_pkg::*;

    localparam int IDX_W = $clog2(`PRR_CFG_DEPTH);
    localparam int ID_W = `CGRA_NUM_PRR_WIDTH;
    localparam logic [ID_W-1:0] MY_ID = ID_W'(PRR_ID);

    logic [`CGRA_CFG_DATA_WIDTH-1:0] regs [`PRR_CFG_DEPTH];
    logic                            overflow;
    logic                            wr_hit;
    logic                            rd_hit;
    logic [IDX_W-1:0]                wr_idx;
    logic [IDX_W-1:0]                rd_idx;
    logic [`CGRA_CFG_DATA_WIDTH-1:0] status_word;

    assign wr_idx = wr_addr[IDX_W-1:0];
    assign rd_idx = rd_addr[IDX_W-1:0];
    assign wr_hit = wr_en && (wr_addr[`CGRA_CFG_ADDR_WIDTH-1 -: ID_W] == MY_ID);
    assign rd_hit = rd_en && (rd_addr[`CGRA_CFG_ADDR_WIDTH-1 -: ID_W] == MY_ID);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `PRR_CFG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit && (wr_idx != REG_STATUS)) begin  // status is not stored
            regs[wr_idx] <= wr_data;
        end
    end

    // sticky, set wins over a clearing write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (overflow_set) begin
            overflow <= 1'b1;
        end else if (wr_hit && (wr_idx == REG_STATUS)) begin
            overflow <= 1'b0;
        end
    end

    assign status_word = {{(`CGRA_CFG_DATA_WIDTH-8){1'b0}}, fifo_count, 3'b000, overflow};

    always_comb begin
        if (!rd_hit) begin
            rd_data = '0;
        end else if (rd_idx == REG_STATUS) begin
            rd_data = status_word;  // live count
        end else begin
            rd_data = regs[rd_idx];
        end
    end

    assign glb2prr_on = regs[REG_CTRL][0];
    assign prr2glb_on = regs[REG_CTRL][1];
    assign op         = prr_op_t'(regs[REG_OP][1:0]);
    assign operand    = regs[REG_OPERAND][`CGRA_IO_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== hw/prr_stream_fifo.sv ====
`default_nettype none

`include "cgra_defs.svh"

module prr_stream_fifo #(
    parameter int DEPTH = `PRR_FIFO_DEPTH
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           push,
    input  logic [`CGRA_IO_WIDTH-1:0]      push_data,
    input  logic                           pop,
    output logic [`CGRA_IO_WIDTH-1:0]      pop_data,
    output logic [$clog2(DEPTH+1)-1:0]     count,
    output logic                           full,
    output logic                           empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    logic [`CGRA_IO_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic                      do_push;
    logic                      do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;    // drop when full
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];  // head word

endmodule

`default_nettype wire

// ==== hw/prr_alu.sv ====
`default_nettype none

`include "cgra_defs.svh"

module prr_alu (
    input  cgra_pkg::prr_op_t              op,
    input  logic [`CGRA_IO_WIDTH-1:0]      operand,
    input  logic [`CGRA_IO_WIDTH-1:0]      data,
    output logic [`CGRA_IO_WIDTH-1:0]      result
);
    import cgra_pkg::*;

    logic [3:0] shamt;

    assign shamt = operand[3:0];  // shl uses low nibble only

    always_comb begin
        case (op)
            OP_PASS: begin
                result = data;
            end
            OP_ADD: begin
                result = data + operand;  // wraps at 16 bits
            end
            OP_XOR: begin
                result = data ^ operand;
            end
            OP_SHL: begin
                result = data << shamt;
            end
            default: begin
                result = data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/prr_tile.sv ====
`default_nettype none

`include "cgra_defs.svh"

module prr_tile #(
    parameter int PRR_ID = 0
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall,
    input  logic                               cfg_wr_en,
    input  logic [`CGRA_CFG_ADDR_WIDTH-1:0]    cfg_wr_addr,
    input  logic [`CGRA_CFG_DATA_WIDTH-1:0]    cfg_wr_data,
    input  logic                               cfg_rd_en,
    input  logic [`CGRA_CFG_ADDR_WIDTH-1:0]    cfg_rd_addr,
    input  logic                               io1_g2io,
    input  logic [`CGRA_IO_WIDTH-1:0]          io16_g2io,
    output logic [`CGRA_CFG_DATA_WIDTH-1:0]    cfg_rd_data,
    output logic                               io1_io2g,
    output logic [`CGRA_IO_WIDTH-1:0]          io16_io2g
);
    import cgra_pkg::*;

    logic                            glb2prr_on;
    logic                            prr2glb_on;
    prr_op_t                         op;
    logic [`CGRA_IO_WIDTH-1:0]       operand;
    logic                            push_req;
    logic                            push;
    logic                            pop;
    logic                            overflow_set;
    logic [`CGRA_IO_WIDTH-1:0]       pop_data;
    logic [`CGRA_IO_WIDTH-1:0]       alu_result;
    logic [`PRR_FIFO_CNT_WIDTH-1:0]  fifo_count;
    logic                            full;
    logic                            empty;

    prr_cfg_regs #(
        .PRR_ID(PRR_ID)
    ) u_cfg (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (cfg_wr_en),
        .wr_addr      (cfg_wr_addr),
        .wr_data      (cfg_wr_data),
        .rd_en        (cfg_rd_en),
        .rd_addr      (cfg_rd_addr),
        .overflow_set (overflow_set),
        .fifo_count   (fifo_count),
        .rd_data      (cfg_rd_data),
        .glb2prr_on   (glb2prr_on),
        .prr2glb_on   (prr2glb_on),
        .op           (op),
        .operand      (operand)
    );

    // stall freezes both sides of the stream
    assign push_req     = !stall && glb2prr_on && io1_g2io;
    assign push         = push_req && !full;
    assign overflow_set = push_req && full;  // word lost
    assign pop          = !stall && prr2glb_on && !empty;

    prr_stream_fifo #(
        .DEPTH(`PRR_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (io16_g2io),
        .pop       (pop),
        .pop_data  (pop_data),
        .count     (fifo_count),
        .full      (full),
        .empty     (empty)
    );

    prr_alu u_alu (
        .op      (op),
        .operand (operand),
        .data    (pop_data),
        .result  (alu_result)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            io1_io2g  <= 1'b0;
            io16_io2g <= '0;
        end else if (!stall) begin  // hold while stalled
            io1_io2g  <= pop;
            io16_io2g <= pop ? alu_result : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cgra.sv ====
`default_nettype none

`include "cgra_defs.svh"

module cgra (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [`CGRA_NUM_PRR-1:0]                               stall,
    input  logic [`CGRA_NUM_PRR-1:0]                               cfg_wr_en,
    input  logic [`CGRA_NUM_PRR-1:0][`CGRA_CFG_ADDR_WIDTH-1:0]     cfg_wr_addr,
    input  logic [`CGRA_NUM_PRR-1:0][`CGRA_CFG_DATA_WIDTH-1:0]     cfg_wr_data,
    input  logic [`CGRA_NUM_PRR-1:0]                               cfg_rd_en,
    input  logic [`CGRA_NUM_PRR-1:0][`CGRA_CFG_ADDR_WIDTH-1:0]     cfg_rd_addr,
    output logic [`CGRA_NUM_PRR-1:0][`CGRA_CFG_DATA_WIDTH-1:0]     cfg_rd_data,
    input  logic [`CGRA_NUM_PRR-1:0]                               io1_g2io,
    input  logic [`CGRA_NUM_PRR-1:0][`CGRA_IO_WIDTH-1:0]           io16_g2io,
    output logic [`CGRA_NUM_PRR-1:0]                               io1_io2g,
    output logic [`CGRA_NUM_PRR-1:0][`CGRA_IO_WIDTH-1:0]           io16_io2g
);

    // one tile per region, slice i only reaches tile i
    for (genvar i = 0; i < `CGRA_NUM_PRR; i++) begin : g_prr
        prr_tile #(
            .PRR_ID(i)
        ) u_tile (
            .clk         (clk),
            .reset       (reset),
            .stall       (stall[i]),
            .cfg_wr_en   (cfg_wr_en[i]),
            .cfg_wr_addr (cfg_wr_addr[i]),
            .cfg_wr_data (cfg_wr_data[i]),
            .cfg_rd_en   (cfg_rd_en[i]),
            .cfg_rd_addr (cfg_rd_addr[i]),
            .io1_g2io    (io1_g2io[i]),
            .io16_g2io   (io16_g2io[i]),
            .cfg_rd_data (cfg_rd_data[i]),
            .io1_io2g    (io1_io2g[i]),
            .io16_io2g   (io16_io2g[i])
        );
    end

endmodule

`default_nettype wire

// ==== bench/cgra_tb.sv ====
`default_nettype none

`include "cgra_defs.svh"

module cgra_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cgra_pkg::*;

    localparam int NUM          = `CGRA_NUM_PRR;
    localparam int DEPTH        = `PRR_FIFO_DEPTH;
    localparam int EXPQ         = 4;
    localparam int SEED         = 81271;
    localparam int RESET_CYCLES = 8;
    localparam int STREAM_LEN   = 150;
    localparam int STALL_LEN    = 300;
    // streaming runs plus drain slack, then config traffic and margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * (STREAM_LEN + 64)
                                  + STALL_LEN + 64 + 600;

    logic                                              clk;
    logic                                              reset;
    logic [NUM-1:0]                                    stall;
    logic [NUM-1:0]                                    cfg_wr_en;
    logic [NUM-1:0][`CGRA_CFG_ADDR_WIDTH-1:0]          cfg_wr_addr;
    logic [NUM-1:0][`CGRA_CFG_DATA_WIDTH-1:0]          cfg_wr_data;
    logic [NUM-1:0]                                    cfg_rd_en;
    logic [NUM-1:0][`CGRA_CFG_ADDR_WIDTH-1:0]          cfg_rd_addr;
    logic [NUM-1:0][`CGRA_CFG_DATA_WIDTH-1:0]          cfg_rd_data;
    logic [NUM-1:0]                                    io1_g2io;
    logic [NUM-1:0][`CGRA_IO_WIDTH-1:0]                io16_g2io;
    logic [NUM-1:0]                                    io1_io2g;
    logic [NUM-1:0][`CGRA_IO_WIDTH-1:0]                io16_io2g;

    // model state, one bounded queue per PRR
    logic [`CGRA_IO_WIDTH-1:0] mq_data [NUM][DEPTH];
    int                        mq_head [NUM];
    int                        mq_cnt  [NUM];
    logic [`CGRA_IO_WIDTH-1:0] exp_data [NUM][EXPQ];
    int                        exp_head [NUM];
    int                        exp_cnt  [NUM];
    logic [1:0]                sh_ctrl [NUM];
    prr_op_t                   sh_op [NUM];
    logic [`CGRA_IO_WIDTH-1:0] sh_operand [NUM];
    logic                      fresh [NUM];     // last edge was unstalled
    logic                      held_v [NUM];
    logic [`CGRA_IO_WIDTH-1:0] held_d [NUM];
    int                        errors;
    int                        cycles;

    cgra dut (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_en   (cfg_rd_en),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rd_data (cfg_rd_data),
        .io1_g2io    (io1_g2io),
        .io16_g2io   (io16_g2io),
        .io1_io2g    (io1_io2g),
        .io16_io2g   (io16_io2g)
    );

    always #5 clk = ~clk;

    function automatic logic [`CGRA_IO_WIDTH-1:0] expected_word(
        input prr_op_t op, input logic [15:0] operand, input logic [15:0] data);
        case (op)
            OP_ADD:  expected_word = data + operand;
            OP_XOR:  expected_word = data ^ operand;
            OP_SHL:  expected_word = data << operand[3:0];
            default: expected_word = data;
        endcase
    endfunction

    function automatic logic [`CGRA_CFG_ADDR_WIDTH-1:0] cfg_addr(input int id, input int idx);
        cfg_addr = '0;
        cfg_addr[`CGRA_CFG_ADDR_WIDTH-1 -: `CGRA_NUM_PRR_WIDTH] = id[`CGRA_NUM_PRR_WIDTH-1:0];
        cfg_addr[3:0] = idx[3:0];
    endfunction

    task automatic fail_now(input string why);
        errors++;
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED %s: expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_cfg(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED %s: expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_op(input string name, input prr_op_t expected, input prr_op_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED %s: expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic write_cfg(input int p, input int id, input int idx, input logic [31:0] data);
        @(posedge clk);
        cfg_wr_en[p]   <= 1'b1;
        cfg_wr_addr[p] <= cfg_addr(id, idx);
        cfg_wr_data[p] <= data;
        @(posedge clk);
        cfg_wr_en[p]   <= 1'b0;
    endtask

    task automatic read_cfg(input int p, input int id, input int idx, input logic en,
                            output logic [31:0] data);
        @(posedge clk);
        cfg_rd_en[p]   <= en;
        cfg_rd_addr[p] <= cfg_addr(id, idx);
        @(negedge clk);
        data = cfg_rd_data[p];  // combinational read
    endtask

    task automatic set_all_ctrl(input logic [1:0] value);
        for (int p = 0; p < NUM; p++) begin
            write_cfg(p, p, REG_CTRL, {30'b0, value});
        end
    endtask

    task automatic stream_words(input int n, input int strobe_pct, input int stall_pct);
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
            for (int p = 0; p < NUM; p++) begin
                io1_g2io[p]  <= ($urandom % 100) < strobe_pct;
                io16_g2io[p] <= 16'($urandom);
                stall[p]     <= ($urandom % 100) < stall_pct;
            end
        end
        @(posedge clk);
        io1_g2io <= '0;
        stall    <= '0;
    endtask

    task automatic wait_drained();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(negedge clk);
            busy = 0;
            for (int p = 0; p < NUM; p++) begin
                busy += mq_cnt[p] + exp_cnt[p];
            end
        end
    endtask

    task automatic reset_state_reads();
        logic [31:0] rd;
        stream_words(10, 100, 0);  // streams off, strobe checked on every edge
        for (int p = 0; p < NUM; p++) begin
            for (int idx = 0; idx < `PRR_CFG_DEPTH; idx++) begin
                read_cfg(p, p, idx, 1'b1, rd);
                check_cfg($sformatf("prr%0d reset reg%0d", p, idx), 32'h0, rd);
            end
            read_cfg(p, p, REG_OP, 1'b1, rd);
            check_op($sformatf("prr%0d reset op", p), OP_PASS, prr_op_t'(rd[1:0]));
        end
    endtask

    task automatic cfg_readback();
        logic [31:0] rd;
        logic [31:0] val;
        for (int p = 0; p < NUM; p++) begin
            val = $urandom;
            write_cfg(p, p, 4 + p, val);
            read_cfg(p, p, 4 + p, 1'b1, rd);
            check_cfg($sformatf("prr%0d scratch", p), val, rd);
            write_cfg(p, (p + 1) % NUM, 9, $urandom);  // other id, must be ignored
            read_cfg(p, p, 9, 1'b1, rd);
            check_cfg($sformatf("prr%0d foreign write", p), 32'h0, rd);
            read_cfg(p, (p + 1) % NUM, 4 + p, 1'b1, rd);
            check_cfg($sformatf("prr%0d foreign read", p), 32'h0, rd);
            read_cfg(p, p, 4 + p, 1'b0, rd);
            check_cfg($sformatf("prr%0d rd_en low", p), 32'h0, rd);
            write_cfg(p, p, REG_OP, 32'(OP_XOR));
            read_cfg(p, p, REG_OP, 1'b1, rd);
            check_op($sformatf("prr%0d op", p), OP_XOR, prr_op_t'(rd[1:0]));
        end
    endtask

    task automatic enable_gating();
        logic [31:0] rd;
        set_all_ctrl(2'b00);
        stream_words(20, 100, 0);
        for (int p = 0; p < NUM; p++) begin
            read_cfg(p, p, REG_STATUS, 1'b1, rd);
            check_cfg($sformatf("prr%0d count input off", p), 32'h0, rd);
        end
        set_all_ctrl(2'b01);
        stream_words(5, 100, 0);
        for (int p = 0; p < NUM; p++) begin
            read_cfg(p, p, REG_STATUS, 1'b1, rd);
            check_cfg($sformatf("prr%0d count output off", p), 32'h50, rd);
        end
        set_all_ctrl(2'b11);
        wait_drained();
    endtask

    task automatic opcode_streams();
        logic [31:0] rd;
        for (int k = 0; k < 4; k++) begin
            for (int p = 0; p < NUM; p++) begin
                write_cfg(p, p, REG_OP, k);
                write_cfg(p, p, REG_OPERAND, $urandom);
                write_cfg(p, p, REG_CTRL, 32'h3);
                read_cfg(p, p, REG_OP, 1'b1, rd);
                check_op($sformatf("prr%0d op %0d", p, k), prr_op_t'(k), prr_op_t'(rd[1:0]));
            end
            stream_words(STREAM_LEN, 50, 0);
            wait_drained();
        end
    endtask

    task automatic stall_streams();
        for (int p = 0; p < NUM; p++) begin
            write_cfg(p, p, REG_OP, $urandom % 4);
            write_cfg(p, p, REG_OPERAND, $urandom);
        end
        stream_words(STALL_LEN, 60, 30);
        wait_drained();
    endtask

    task automatic overflow_drop();
        logic [31:0] rd;
        set_all_ctrl(2'b01);
        stream_words(DEPTH + 3, 100, 0);
        for (int p = 0; p < NUM; p++) begin
            read_cfg(p, p, REG_STATUS, 1'b1, rd);
            check_cfg($sformatf("prr%0d overflow set", p), 32'(DEPTH * 16 + 1), rd);
            write_cfg(p, p, REG_STATUS, 32'h0);
            read_cfg(p, p, REG_STATUS, 1'b1, rd);
            check_cfg($sformatf("prr%0d overflow clear", p), 32'(DEPTH * 16), rd);
        end
        set_all_ctrl(2'b11);
        wait_drained();
    endtask

    // mirror of the tile rules, evaluated on the same edge as the DUT
    always @(posedge clk) begin
        logic                      push_req;
        logic                      full_now;
        logic [3:0]                idx;
        logic [`CGRA_IO_WIDTH-1:0] w;
        for (int p = 0; p < NUM; p++) begin
            if (reset) begin
                mq_head[p]    = 0;
                mq_cnt[p]     = 0;
                exp_head[p]   = 0;
                exp_cnt[p]    = 0;
                sh_ctrl[p]    = 2'b00;
                sh_op[p]      = OP_PASS;
                sh_operand[p] = '0;
                fresh[p]      = 1'b0;
            end else begin
                fresh[p] = !stall[p];
                if (!stall[p]) begin
                    push_req = sh_ctrl[p][0] && io1_g2io[p];
                    full_now = (mq_cnt[p] == DEPTH);
                    if (sh_ctrl[p][1] && mq_cnt[p] != 0) begin
                        w = mq_data[p][mq_head[p]];
                        mq_head[p] = (mq_head[p] + 1) % DEPTH;
                        mq_cnt[p]--;
                        exp_data[p][(exp_head[p] + exp_cnt[p]) % EXPQ] =
                            expected_word(sh_op[p], sh_operand[p], w);
                        exp_cnt[p]++;
                    end
                    if (push_req && !full_now) begin  // word dropped when full
                        mq_data[p][(mq_head[p] + mq_cnt[p]) % DEPTH] = io16_g2io[p];
                        mq_cnt[p]++;
                    end
                end
                idx = cfg_wr_addr[p][3:0];
                if (cfg_wr_en[p] && cfg_wr_addr[p][`CGRA_CFG_ADDR_WIDTH-1 -: 2] == 2'(p)) begin
                    case (idx)
                        4'd0: sh_ctrl[p] = cfg_wr_data[p][1:0];
                        4'd1: sh_op[p] = prr_op_t'(cfg_wr_data[p][1:0]);
                        4'd2: sh_operand[p] = cfg_wr_data[p][15:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        for (int p = 0; p < NUM; p++) begin
            if (reset) begin
                held_v[p] = 1'b0;
                held_d[p] = '0;
            end else begin
                if (fresh[p] && io1_io2g[p]) begin
                    if (exp_cnt[p] == 0) begin
                        fail_now($sformatf("output pulse on prr%0d with no word expected", p));
                    end
                    check_data($sformatf("prr%0d out", p), exp_data[p][exp_head[p]], io16_io2g[p]);
                    exp_head[p] = (exp_head[p] + 1) % EXPQ;
                    exp_cnt[p]--;
                end else if (fresh[p]) begin
                    if (exp_cnt[p] != 0) begin
                        fail_now($sformatf("expected output word missing on prr%0d", p));
                    end
                    check_data($sformatf("prr%0d idle", p), 16'h0, io16_io2g[p]);
                end else begin
                    if (io1_io2g[p] !== held_v[p]) begin
                        fail_now($sformatf("output strobe of prr%0d changed during stall", p));
                    end
                    check_data($sformatf("prr%0d hold", p), held_d[p], io16_io2g[p]);
                end
                held_v[p] = io1_io2g[p];
                held_d[p] = io16_io2g[p];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        stall       = '0;
        cfg_wr_en   = '0;
        cfg_wr_addr = '0;
        cfg_wr_data = '0;
        cfg_rd_en   = '0;
        cfg_rd_addr = '0;
        io1_g2io    = '0;
        io16_g2io   = '0;
        errors      = 0;
        cycles      = 0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        reset_state_reads();
        cfg_readback();
        enable_gating();
        opcode_streams();
        stall_streams();
        overflow_drop();
        repeat (4) @(posedge clk);

        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/cgra_pkg.sv
hw/prr_cfg_regs.sv
hw/prr_stream_fifo.sv
hw/prr_alu.sv
hw/prr_tile.sv
hw/cgra.sv
bench/cgra_tb.sv
